// ==== files.f ====
design/nocPkg.sv
design/arbPkg.sv
design/portReqIf.sv
design/timerBank.sv
design/portArbiter.sv
design/flitForward.sv
design/outputPort.sv
bench/tbOutputPort.sv

// ==== Makefile ====
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f files.f --top-module tbOutputPort \
		-Mdir $(BUILD) -o simOutputPort

run: compile
	./$(BUILD)/simOutputPort > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

// ==== bench/tbOutputPort.sv ====
`timescale 1ns/1ps

module tbOutputPort;

  localparam int ClkPeriod = 100;
  localparam int ResetCycles = 3;
  localparam int DirectedCycles = 80;
  localparam int RandomCycles = 2000;
  localparam int TotalCycles = ResetCycles + DirectedCycles + RandomCycles;

  logic clk;
  logic rst;
  logic [nocPkg::NumPorts-1:0] req;
  nocPkg::flitKind_e kind [nocPkg::NumPorts];
  logic [nocPkg::LenWidth-1:0] length [nocPkg::NumPorts];
  logic [nocPkg::FlitWidth-1:0] data [nocPkg::NumPorts];
  logic [arbPkg::GrantWidth-1:0] grant;
  logic [nocPkg::FlitWidth-1:0] outFlit;
  logic outValid;

  logic [31:0] lcgState = 32'h7ba3_4b80;

  // Reference model state. Port index of the owner, or -1 when idle.
  int mState = -1;
  logic [nocPkg::LenWidth-1:0] mLimit [nocPkg::NumPorts];
  logic [nocPkg::LenWidth-1:0] mCount [nocPkg::NumPorts];
  logic expValid;
  logic [nocPkg::FlitWidth-1:0] expFlit;

  outputPort dut0
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .kind     (kind),
    .length   (length),
    .data     (data),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic void stepModel();
    int nextState;
    int first;
    int span;
    int cand;
    logic [nocPkg::NumPorts-1:0] run;
    nextState = -1;
    run = '0;
    if ((mState >= 0) && req[mState] && (mCount[mState] != mLimit[mState]))
    begin
      nextState = mState;
      run[mState] = 1'b1;
    end
    else
    begin
      first = (mState < 0) ? 0 : mState + 1;
      span = (mState < 0) ? nocPkg::NumPorts : nocPkg::NumPorts - 1;
      for (int i = span - 1; i >= 0; i--)
      begin
        cand = (first + i) % nocPkg::NumPorts;
        if (req[cand])
        begin
          nextState = cand; // Walking backwards leaves the earliest requester.
        end
      end
    end
    expValid = 1'b0;
    if (mState >= 0)
    begin
      expValid = req[mState];
      if (req[mState])
      begin
        expFlit = data[mState];
      end
    end
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      if (kind[p] == nocPkg::KindHeader)
      begin
        mLimit[p] = length[p];
      end
      mCount[p] = run[p] ? mCount[p] + 1'b1 : '0;
    end
    mState = nextState;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      mState = -1;
      expValid = 1'b0;
      for (int p = 0; p < nocPkg::NumPorts; p++)
      begin
        mLimit[p] = '0;
        mCount[p] = '0;
      end
    end
    else
    begin
      stepModel();
    end
  end

  task automatic reportMismatch(input string msg);
    $display("[ERROR] %0d ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic compareOutputs();
    logic [arbPkg::GrantWidth-1:0] expGrant;
    expGrant = (mState < 0) ? '0 : (5'b00001 << mState);
    assert (grant === expGrant)
      else reportMismatch($sformatf("grant %b, expected %b", grant, expGrant));
    assert (outValid === expValid)
      else reportMismatch($sformatf("outValid %b, expected %b", outValid, expValid));
    if (expValid)
    begin
      assert (outFlit === expFlit)
        else reportMismatch($sformatf("outFlit %h, expected %h", outFlit, expFlit));
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst)
    begin
      compareOutputs();
    end
  end

  // Drives one cycle of inputs. hdrPort of -1 sends no header.
  task automatic stepCycle(input logic [4:0] r, input int hdrPort,
                           input logic [nocPkg::LenWidth-1:0] len);
    @(posedge clk);
    req <= r;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      kind[p] <= (p == hdrPort) ? nocPkg::KindHeader
               : (r[p] ? nocPkg::KindBody : nocPkg::KindIdle);
      length[p] <= (p == hdrPort) ? len : '0;
      data[p] <= nextRand();
    end
  endtask

  task automatic checkHold(input int port, input logic [nocPkg::LenWidth-1:0] n);
    logic [4:0] mask;
    int held;
    int waited;
    mask = 5'b00001 << port;
    held = 0;
    waited = 0;
    stepCycle(mask, port, n);
    stepCycle(mask, -1, '0);
    @(negedge clk);
    while ((grant != mask) && (waited < 10))
    begin
      waited++;
      @(negedge clk);
    end
    while ((grant == mask) && (held < 100))
    begin
      held++;
      @(negedge clk);
    end
    assert (held == n + 1)
      else reportMismatch($sformatf("port %0d held %0d cycles, expected %0d", port, held, n + 1));
    assert (grant == '0)
      else reportMismatch($sformatf("grant %b after hold, expected idle", grant));
    @(negedge clk);
    assert (grant == mask)
      else reportMismatch($sformatf("grant %b, expected port %0d again", grant, port));
    stepCycle('0, -1, '0);
    repeat (2) stepCycle('0, -1, '0);
  endtask

  initial
  begin
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < nocPkg::NumPorts; p++)
    begin
      kind[p] = nocPkg::KindIdle;
      length[p] = '0;
      data[p] = '0;
    end
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    repeat (4) stepCycle('0, -1, '0);
    @(negedge clk);
    assert ((grant == '0) && (outValid == 1'b0))
      else reportMismatch($sformatf("idle outputs grant %b outValid %b", grant, outValid));

    // N, E and S request together; N is first in the idle scan.
    stepCycle(5'b10110, -1, '0);
    @(posedge clk);
    @(negedge clk);
    assert (grant == 5'b00010)
      else reportMismatch($sformatf("priority grant %b, expected 00010", grant));
    repeat (3) stepCycle('0, -1, '0);

    checkHold(int'(nocPkg::PortE), 12'd0);
    checkHold(int'(nocPkg::PortE), 12'd3);
    checkHold(int'(nocPkg::PortL), 12'd6);

    // W releases while N and S wait; S follows W in the rotation.
    stepCycle(5'b01000, int'(nocPkg::PortW), 12'd20);
    stepCycle(5'b11010, -1, '0);
    stepCycle(5'b10010, -1, '0);
    @(posedge clk);
    @(negedge clk);
    assert (grant == 5'b10000)
      else reportMismatch($sformatf("rotation grant %b, expected 10000", grant));
    repeat (4) stepCycle('0, -1, '0);

    repeat (RandomCycles)
    begin
      @(posedge clk);
      req <= nextRand() >> 27;
      for (int p = 0; p < nocPkg::NumPorts; p++)
      begin
        logic [31:0] r;
        r = nextRand();
        kind[p] <= nocPkg::flitKind_e'({1'b0, r[9:8]});
        length[p] <= {8'd0, r[13:10]}; // Short limits give many releases.
        data[p] <= nextRand();
      end
    end
    repeat (3) stepCycle('0, -1, '0);
    @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

  initial
  begin
    #((TotalCycles + 50) * ClkPeriod);
    $display("Timeout: the test did not finish in the expected number of cycles.");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== design/outputPort.sv ====
`timescale 1ns/1ps

module outputPort
(
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::NumPorts-1:0] req,
  input  nocPkg::flitKind_e kind [nocPkg::NumPorts],
  input  logic [nocPkg::LenWidth-1:0] length [nocPkg::NumPorts],
  input  logic [nocPkg::FlitWidth-1:0] data [nocPkg::NumPorts],
  output logic [arbPkg::GrantWidth-1:0] grant,
  output logic [nocPkg::FlitWidth-1:0] outFlit,
  output logic outValid
);

  logic [nocPkg::NumPorts-1:0] runTimer;
  logic [nocPkg::NumPorts-1:0] timesUp;

  portReqIf reqBus ();

  // Input ports feed the shared request bundle.
  assign reqBus.req = req;
  assign reqBus.kind = kind;
  assign reqBus.length = length;
  assign reqBus.data = data;

  portArbiter arb0
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqBus.sink),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant)
  );

  timerBank timers0
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqBus.sink),
    .runTimer (runTimer),
    .timesUp  (timesUp)
  );

  flitForward fwd0
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqBus.sink),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// ==== design/flitForward.sv ====
`timescale 1ns/1ps

module flitForward
(
  input  logic clk,
  input  logic rst,
  portReqIf.sink reqs,
  input  logic [arbPkg::GrantWidth-1:0] grant,
  output logic [nocPkg::FlitWidth-1:0] outFlit,
  output logic outValid
);

  logic [nocPkg::FlitWidth-1:0] selData;
  logic selReq;

  // One-hot mux, so OR-ing the masked inputs picks the granted port.
  always_comb
  begin
    selData = '0;
    selReq = 1'b0;
    for (int p = int'(nocPkg::PortL); p <= int'(nocPkg::PortS); p++)
    begin
      if (grant[p])
      begin
        selData |= reqs.data[p];
        selReq |= reqs.req[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selReq;
    end
  end

  always_ff @(posedge clk)
  begin
    if (selReq)
    begin
      outFlit <= selData; // Holds the last flit when nothing is forwarded.
    end
  end

  assert property (@(posedge clk) disable iff (rst) (grant == '0) |=> !outValid)
    else $error("outValid raised after an idle cycle");

endmodule

// ==== design/portArbiter.sv ====
`timescale 1ns/1ps

module portArbiter
(
  input  logic clk,
  input  logic rst,
  portReqIf.sink reqs,
  input  logic [nocPkg::NumPorts-1:0] timesUp,
  output logic [nocPkg::NumPorts-1:0] runTimer,
  output logic [arbPkg::GrantWidth-1:0] grant
);

  arbPkg::arbState_e state;
  arbPkg::arbState_e stateNext;
  nocPkg::portId_e curPort;
  logic granted;

  function automatic arbPkg::arbState_e stateFor(input int unsigned p);
    return arbPkg::arbState_e'({{(arbPkg::StateWidth-1){1'b0}}, 1'b1} << (p + 1));
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbPkg::ArbIdle;
    end
    else
    begin
      state <= stateNext;
    end
  end

  // Port currently owning the output.
  always_comb
  begin
    granted = 1'b1;
    curPort = nocPkg::PortL;
    case (state)
      arbPkg::ArbGrantL: curPort = nocPkg::PortL;
      arbPkg::ArbGrantN: curPort = nocPkg::PortN;
      arbPkg::ArbGrantE: curPort = nocPkg::PortE;
      arbPkg::ArbGrantW: curPort = nocPkg::PortW;
      arbPkg::ArbGrantS: curPort = nocPkg::PortS;
      default: granted = 1'b0; // Idle or an illegal code.
    endcase
  end

  always_comb
  begin : nextStateLogic
    int unsigned base;
    int unsigned firstOff;
    int unsigned idx;
    logic found;
    base = 0;
    firstOff = 0;
    idx = 0;
    found = 1'b0;
    stateNext = arbPkg::ArbIdle; // Illegal codes fall back here.
    runTimer = '0;
    if (granted && reqs.req[curPort] && !timesUp[curPort])
    begin
      stateNext = state;
      runTimer[curPort] = 1'b1;
    end
    else if (granted || (state == arbPkg::ArbIdle))
    begin
      // From idle scan L first; on release start after the owner and skip it.
      if (granted)
      begin
        base = int'(curPort);
        firstOff = 1;
      end
      for (int off = 0; off < nocPkg::NumPorts; off++)
      begin
        if ((off >= firstOff) && !found)
        begin
          idx = (base + off) % nocPkg::NumPorts;
          if (reqs.req[idx])
          begin
            found = 1'b1;
            stateNext = stateFor(idx);
          end
        end
      end
    end
  end

  assign grant = granted ? ({{(arbPkg::GrantWidth-1){1'b0}}, 1'b1} << curPort) : '0;

  // Grants are one-hot and go only to ports that requested a cycle earlier.
  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~$past(reqs.req)) == '0))
    else $error("grant %b is not one-hot or lacks a request", grant);

  // A timer runs only for the owner, and the owner keeps the output next cycle.
  assert property (@(posedge clk) disable iff (rst)
    (runTimer != '0) |=> ($stable(grant) && (($past(runTimer) & ~grant) == '0)))
    else $error("runTimer %b outside grant %b", runTimer, grant);

endmodule

// ==== design/timerBank.sv ====
`timescale 1ns/1ps

module timerBank
(
  input  logic clk,
  input  logic rst,
  portReqIf.sink reqs,
  input  logic [nocPkg::NumPorts-1:0] runTimer,
  output logic [nocPkg::NumPorts-1:0] timesUp
);

  for (genvar p = 0; p < nocPkg::NumPorts; p++)
  begin : genTimer
    logic [nocPkg::LenWidth-1:0] limit;
    logic [nocPkg::LenWidth-1:0] count;

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        limit <= '0;
        count <= '0;
      end
      else
      begin
        if (reqs.kind[p] == nocPkg::KindHeader)
        begin
          limit <= reqs.length[p]; // A new header re-arms the hold limit.
        end
        if (runTimer[p])
        begin
          count <= count + 1'b1;
        end
        else
        begin
          count <= '0; // Count restarts whenever the port is not holding.
        end
      end
    end

    assign timesUp[p] = (count == limit);

    // The arbiter releases on timesUp, so a hold within an unchanged limit
    // never steps past that limit.
    assert property (@(posedge clk) disable iff (rst)
      (runTimer[p] && (count <= limit) && (reqs.kind[p] != nocPkg::KindHeader))
      |=> (count <= limit))
      else $error("timer %0d ran past its limit", p);
  end

endmodule

// ==== design/portReqIf.sv ====
`timescale 1ns/1ps

interface portReqIf;

  logic [nocPkg::NumPorts-1:0] req;
  nocPkg::flitKind_e kind [nocPkg::NumPorts];
  logic [nocPkg::LenWidth-1:0] length [nocPkg::NumPorts];
  logic [nocPkg::FlitWidth-1:0] data [nocPkg::NumPorts];

  modport source
  (
    output req,
    output kind,
    output length,
    output data
  );

  modport sink
  (
    input req,
    input kind,
    input length,
    input data
  );

endinterface

// ==== design/arbPkg.sv ====
package arbPkg;

  localparam int StateWidth = nocPkg::NumPorts + 1;
  localparam int GrantWidth = nocPkg::NumPorts;

  // One-hot states. Bit 0 is idle and bit p+1 grants port p.
  typedef enum logic [StateWidth-1:0]
  {
    ArbIdle   = 6'b000001,
    ArbGrantL = 6'b000010,
    ArbGrantN = 6'b000100,
    ArbGrantE = 6'b001000,
    ArbGrantW = 6'b010000,
    ArbGrantS = 6'b100000
  } arbState_e;

endpackage

// ==== design/nocPkg.sv ====
package nocPkg;

  localparam int NumPorts = 5;
  localparam int FlitWidth = 32;
  localparam int LenWidth = 12;

  // Kind code sent alongside each flit; only headers carry a valid length.
  typedef enum logic [2:0]
  {
    KindIdle   = 3'd0,
    KindHeader = 3'd1,
    KindBody   = 3'd2,
    KindTail   = 3'd3
  } flitKind_e;

  // Port numbering; it also sets the fixed scan order out of idle.
  typedef enum logic [2:0]
  {
    PortL = 3'd0,
    PortN = 3'd1,
    PortE = 3'd2,
    PortW = 3'd3,
    PortS = 3'd4
  } portId_e;

endpackage
